// ==== common/lc3b_isa_pkg.sv ====
`default_nettype none

package lc3b_isa_pkg;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;

    // only the opcodes this core executes
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    // add, and, not
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dr;
        lc3b_reg    sr1;
        logic       imm_flag;
        // sr2 sits in the low three bits when imm_flag is clear
        logic [4:0] imm5;
    } lc3b_oper_s;

    // ldr, str and br
    // for br, dr carries nzp and {base, offset6} is offset9
    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dr;
        lc3b_reg    base;
        logic [5:0] offset6;
    } lc3b_mem_s;

    typedef union packed {
        lc3b_oper_s oper;
        lc3b_mem_s  mem;
    } lc3b_instr_u;

endpackage : lc3b_isa_pkg

`default_nettype wire

// ==== common/lc3b_pipe_pkg.sv ====
`default_nettype none

package lc3b_pipe_pkg;

    import lc3b_isa_pkg::*;

    // alu_addr is base plus offset6, scaled to words
    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_addr
    } lc3b_alu_op_e;

    // all zero is a no-op
    typedef struct packed {
        lc3b_alu_op_e alu_op;
        logic         opb_imm;
        logic         mem_read;
        logic         mem_write;
        logic         load_regfile;
        logic         load_cc;
        logic         is_branch;
    } lc3b_ctrl_s;

    typedef struct packed {
        lc3b_word    pc;
        lc3b_instr_u ir;
        logic        valid;
    } lc3b_if_id_s;

    typedef struct packed {
        lc3b_ctrl_s  ctrl;
        lc3b_word    pc;
        lc3b_reg     src1;
        lc3b_reg     src2;
        lc3b_word    src1_data;
        lc3b_word    src2_data;
        lc3b_reg     dest;
        lc3b_instr_u ir;
    } lc3b_id_ex_s;

    typedef struct packed {
        lc3b_ctrl_s ctrl;
        lc3b_reg    dest;
        lc3b_word   alu;
        lc3b_word   wdata;
        lc3b_word   target;
    } lc3b_ex_mem_s;

    typedef struct packed {
        lc3b_ctrl_s ctrl;
        lc3b_reg    dest;
        lc3b_word   alu;
        lc3b_word   rdata;
        lc3b_word   target;
    } lc3b_mem_wb_s;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } lc3b_fwd_sel_e;

endpackage : lc3b_pipe_pkg

`default_nettype wire

// ==== pipeline/fetch_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_stage
    import lc3b_isa_pkg::*, lc3b_pipe_pkg::*;
#(
    parameter lc3b_word P_RESET_PC = 16'h0000
) (
    input  wire           clk,
    input  wire           i_rst,
    input  wire           i_advance,
    input  wire           i_hold_pc,
    input  wire           i_flush,
    input  wire           i_redirect,
    input  wire lc3b_word i_target,
    input  wire           i_imem_resp,
    input  wire lc3b_word i_imem_rdata,
    output lc3b_word      o_imem_address,
    output logic          o_imem_read,
    output lc3b_if_id_s   o_if_id
);

    lc3b_word pc_q;
    lc3b_word pc_plus2;
    logic     fetch_on;
    logic     ibuf_valid;
    lc3b_word ibuf_q;
    lc3b_word word;
    logic     have_word;
    logic     take;

    assign pc_plus2       = pc_q + 16'd2;
    assign o_imem_address = pc_q;
    // request until a word is in hand, either answered now or parked
    assign o_imem_read    = fetch_on & ~ibuf_valid;
    assign word           = ibuf_valid ? ibuf_q : i_imem_rdata;
    assign have_word      = ibuf_valid | o_imem_read;
    assign take           = i_advance & ~i_hold_pc & have_word;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            pc_q          <= P_RESET_PC;
            fetch_on      <= 1'b0;
            ibuf_valid    <= 1'b0;
            o_if_id.valid <= 1'b0;
        end else begin
            fetch_on <= 1'b1;
            if (i_advance && i_redirect) begin
                pc_q       <= i_target;
                ibuf_valid <= 1'b0;
            end else if (take) begin
                pc_q       <= pc_plus2;
                ibuf_valid <= 1'b0;
            end else if (o_imem_read && i_imem_resp) begin
                // answered but not consumed this cycle
                ibuf_valid <= 1'b1;
            end
            if (i_advance && !i_hold_pc) begin
                o_if_id.valid <= have_word & ~i_flush;
                o_if_id.pc    <= pc_plus2;
                o_if_id.ir    <= word;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_imem_read && i_imem_resp) begin
            ibuf_q <= i_imem_rdata;
        end
    end

endmodule : fetch_stage

`default_nettype wire

// ==== pipeline/decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage
    import lc3b_isa_pkg::*, lc3b_pipe_pkg::*;
(
    input  wire              clk,
    input  wire              i_rst,
    input  wire              i_advance,
    input  wire              i_bubble,
    input  wire              i_flush,
    input  wire lc3b_if_id_s i_if_id,
    input  wire              i_rf_we,
    input  wire lc3b_reg     i_rf_dest,
    input  wire lc3b_word    i_rf_data,
    output lc3b_reg          o_src_a,
    output lc3b_reg          o_src_b,
    output lc3b_id_ex_s      o_id_ex
);

    lc3b_word    rf_q [8];
    lc3b_instr_u ir;
    lc3b_ctrl_s  ctrl;
    lc3b_word    data_a;
    lc3b_word    data_b;
    lc3b_id_ex_s id_ex_d;

    assign ir      = i_if_id.ir;
    assign o_src_a = ir.oper.sr1;
    // str reads its store data from the dr field
    assign o_src_b = (ir.mem.opcode == op_str) ? ir.mem.dr : ir.oper.imm5[2:0];

    always_comb begin
        ctrl = '0;
        if (i_if_id.valid) begin
            case (ir.oper.opcode)
                op_add: begin
                    ctrl.alu_op       = alu_add;
                    ctrl.opb_imm      = ir.oper.imm_flag;
                    ctrl.load_regfile = 1'b1;
                    ctrl.load_cc      = 1'b1;
                end
                op_and: begin
                    ctrl.alu_op       = alu_and;
                    ctrl.opb_imm      = ir.oper.imm_flag;
                    ctrl.load_regfile = 1'b1;
                    ctrl.load_cc      = 1'b1;
                end
                op_not: begin
                    ctrl.alu_op       = alu_not;
                    ctrl.load_regfile = 1'b1;
                    ctrl.load_cc      = 1'b1;
                end
                op_ldr: begin
                    ctrl.alu_op       = alu_addr;
                    ctrl.mem_read     = 1'b1;
                    ctrl.load_regfile = 1'b1;
                    ctrl.load_cc      = 1'b1;
                end
                op_str: begin
                    ctrl.alu_op    = alu_addr;
                    ctrl.mem_write = 1'b1;
                end
                op_br: begin
                    ctrl.is_branch = 1'b1;
                end
                default: ctrl = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_rf_we) begin
            rf_q[i_rf_dest] <= i_rf_data;
        end
    end

    // a value retiring in the same cycle bypasses the array
    assign data_a = (i_rf_we && i_rf_dest == o_src_a) ? i_rf_data : rf_q[o_src_a];
    assign data_b = (i_rf_we && i_rf_dest == o_src_b) ? i_rf_data : rf_q[o_src_b];

    always_comb begin
        id_ex_d.ctrl      = (i_bubble || i_flush) ? '0 : ctrl;
        id_ex_d.pc        = i_if_id.pc;
        id_ex_d.src1      = o_src_a;
        id_ex_d.src2      = o_src_b;
        id_ex_d.src1_data = data_a;
        id_ex_d.src2_data = data_b;
        id_ex_d.dest      = ir.oper.dr;
        id_ex_d.ir        = ir;
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_id_ex.ctrl <= '0;
        end else if (i_advance) begin
            o_id_ex <= id_ex_d;
        end
    end

endmodule : decode_stage

`default_nettype wire

// ==== pipeline/execute_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute_stage
    import lc3b_isa_pkg::*, lc3b_pipe_pkg::*;
(
    input  wire                clk,
    input  wire                i_rst,
    input  wire                i_advance,
    input  wire                i_flush,
    input  wire lc3b_id_ex_s   i_id_ex,
    input  wire lc3b_fwd_sel_e i_fwd_a,
    input  wire lc3b_fwd_sel_e i_fwd_b,
    input  wire lc3b_word      i_mem_fwd,
    input  wire lc3b_word      i_wb_fwd,
    output lc3b_ex_mem_s       o_ex_mem
);

    lc3b_instr_u  ir;
    lc3b_word     opnd_a;
    lc3b_word     src_b;
    lc3b_word     opnd_b;
    lc3b_word     imm5;
    lc3b_word     off6;
    lc3b_word     off9;
    lc3b_word     alu_out;
    lc3b_ex_mem_s ex_mem_d;

    function automatic lc3b_word fwd_pick(lc3b_fwd_sel_e sel, lc3b_word rf_val);
        case (sel)
            fwd_mem: return i_mem_fwd;
            fwd_wb:  return i_wb_fwd;
            default: return rf_val;
        endcase
    endfunction

    assign ir     = i_id_ex.ir;

    always_comb begin
        opnd_a = fwd_pick(i_fwd_a, i_id_ex.src1_data);
        src_b  = fwd_pick(i_fwd_b, i_id_ex.src2_data);
    end

    assign imm5   = {{11{ir.oper.imm5[4]}}, ir.oper.imm5};
    assign off6   = {{10{ir.mem.offset6[5]}}, ir.mem.offset6};
    // offset9 spans the base and offset6 fields
    assign off9   = {{7{ir.mem.base[2]}}, ir.mem.base, ir.mem.offset6};
    assign opnd_b = i_id_ex.ctrl.opb_imm ? imm5 : src_b;

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            alu_add: alu_out = opnd_a + opnd_b;
            alu_and: alu_out = opnd_a & opnd_b;
            alu_not: alu_out = ~opnd_a;
            default: alu_out = opnd_a + {off6[14:0], 1'b0};
        endcase
    end

    always_comb begin
        ex_mem_d.ctrl   = i_flush ? '0 : i_id_ex.ctrl;
        ex_mem_d.dest   = i_id_ex.dest;
        ex_mem_d.alu    = alu_out;
        // store data is the forwarded second source, not operand b
        ex_mem_d.wdata  = src_b;
        ex_mem_d.target = i_id_ex.pc + {off9[14:0], 1'b0};
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_ex_mem.ctrl <= '0;
        end else if (i_advance) begin
            o_ex_mem <= ex_mem_d;
        end
    end

endmodule : execute_stage

`default_nettype wire

// ==== pipeline/memory_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module memory_stage
    import lc3b_isa_pkg::*, lc3b_pipe_pkg::*;
(
    input  wire               clk,
    input  wire               i_rst,
    input  wire               i_advance,
    input  wire               i_flush,
    input  wire lc3b_ex_mem_s i_ex_mem,
    input  wire               i_dmem_resp,
    input  wire lc3b_word     i_dmem_rdata,
    output lc3b_word          o_dmem_address,
    output lc3b_word          o_dmem_wdata,
    output logic              o_dmem_read,
    output logic              o_dmem_write,
    output lc3b_word          o_mem_fwd,
    output lc3b_mem_wb_s      o_mem_wb
);

    logic         done_q;
    lc3b_word     rdata_q;
    lc3b_mem_wb_s mem_wb_d;

    assign o_dmem_address = i_ex_mem.alu;
    assign o_dmem_wdata   = i_ex_mem.wdata;
    // nothing goes out behind a taken branch or after the answer came
    assign o_dmem_read    = i_ex_mem.ctrl.mem_read & ~done_q & ~i_flush;
    assign o_dmem_write   = i_ex_mem.ctrl.mem_write & ~done_q & ~i_flush;
    assign o_mem_fwd      = i_ex_mem.alu;

    // access finished while the fetch side still waits
    always_ff @(posedge clk) begin
        if (i_rst || i_advance) begin
            done_q <= 1'b0;
        end else if (i_dmem_resp && (o_dmem_read || o_dmem_write)) begin
            done_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_dmem_resp && o_dmem_read) begin
            rdata_q <= i_dmem_rdata;
        end
    end

    always_comb begin
        mem_wb_d.ctrl   = i_flush ? '0 : i_ex_mem.ctrl;
        mem_wb_d.dest   = i_ex_mem.dest;
        mem_wb_d.alu    = i_ex_mem.alu;
        mem_wb_d.rdata  = done_q ? rdata_q : i_dmem_rdata;
        mem_wb_d.target = i_ex_mem.target;
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_mem_wb.ctrl <= '0;
        end else if (i_advance) begin
            o_mem_wb <= mem_wb_d;
        end
    end

endmodule : memory_stage

`default_nettype wire

// ==== pipeline/writeback_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module writeback_stage
    import lc3b_isa_pkg::*, lc3b_pipe_pkg::*;
(
    input  wire               clk,
    input  wire               i_rst,
    input  wire               i_advance,
    input  wire lc3b_mem_wb_s i_mem_wb,
    output logic              o_rf_we,
    output lc3b_reg           o_rf_dest,
    output lc3b_word          o_rf_data,
    output lc3b_word          o_wb_fwd,
    output logic              o_redirect,
    output lc3b_word          o_target
);

    lc3b_word wb_value;
    lc3b_nzp  cc_d;
    lc3b_nzp  cc_q;

    assign wb_value  = i_mem_wb.ctrl.mem_read ? i_mem_wb.rdata : i_mem_wb.alu;
    assign o_rf_we   = i_mem_wb.ctrl.load_regfile & i_advance;
    assign o_rf_dest = i_mem_wb.dest;
    assign o_rf_data = wb_value;
    assign o_wb_fwd  = wb_value;

    always_comb begin
        if (wb_value[15]) begin
            cc_d = 3'b100;
        end else if (wb_value == 16'h0000) begin
            cc_d = 3'b010;
        end else begin
            cc_d = 3'b001;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            cc_q <= 3'b000;
        end else if (i_advance && i_mem_wb.ctrl.load_cc) begin
            cc_q <= cc_d;
        end
    end

    // br keeps its nzp mask in the dest field
    assign o_redirect = i_mem_wb.ctrl.is_branch & |(i_mem_wb.dest & cc_q);
    assign o_target   = i_mem_wb.target;

endmodule : writeback_stage

`default_nettype wire

// ==== source/hazard_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazard_unit
    import lc3b_isa_pkg::*, lc3b_pipe_pkg::*;
(
    input  wire               i_imem_read,
    input  wire               i_imem_resp,
    input  wire               i_dmem_req,
    input  wire               i_dmem_resp,
    input  wire               i_redirect,
    input  wire lc3b_id_ex_s  i_id_ex,
    input  wire lc3b_ex_mem_s i_ex_mem,
    input  wire lc3b_mem_wb_s i_mem_wb,
    input  wire lc3b_reg      i_id_src_a,
    input  wire lc3b_reg      i_id_src_b,
    output logic              o_advance,
    output logic              o_bubble,
    output logic              o_hold_pc,
    output logic              o_flush,
    output lc3b_fwd_sel_e     o_fwd_a,
    output lc3b_fwd_sel_e     o_fwd_b
);

    logic imem_wait;
    logic dmem_wait;
    logic load_use;

    // mem wins over wb, a load in mem has no data yet
    function automatic lc3b_fwd_sel_e fwd_sel(lc3b_reg src);
        if (i_ex_mem.ctrl.load_regfile && !i_ex_mem.ctrl.mem_read && i_ex_mem.dest == src) begin
            return fwd_mem;
        end else if (i_mem_wb.ctrl.load_regfile && i_mem_wb.dest == src) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    assign imem_wait = i_imem_read & ~i_imem_resp;
    assign dmem_wait = i_dmem_req & ~i_dmem_resp;
    assign o_advance = ~imem_wait & ~dmem_wait;

    // load in ex feeding the word in id
    assign load_use  = i_id_ex.ctrl.mem_read &
                       (i_id_ex.dest == i_id_src_a || i_id_ex.dest == i_id_src_b);
    assign o_bubble  = load_use & ~i_redirect;
    assign o_hold_pc = o_bubble;
    assign o_flush   = i_redirect;

    always_comb begin
        o_fwd_a = fwd_sel(i_id_ex.src1);
        o_fwd_b = fwd_sel(i_id_ex.src2);
    end

endmodule : hazard_unit

`default_nettype wire

// ==== source/cpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_top
    import lc3b_isa_pkg::*, lc3b_pipe_pkg::*;
#(
    parameter lc3b_word P_RESET_PC = 16'h0000
) (
    input  wire           clk,
    input  wire           i_rst,
    input  wire           i_imem_resp,
    input  wire lc3b_word i_imem_rdata,
    output lc3b_word      o_imem_address,
    output logic          o_imem_read,
    input  wire           i_dmem_resp,
    input  wire lc3b_word i_dmem_rdata,
    output lc3b_word      o_dmem_address,
    output lc3b_word      o_dmem_wdata,
    output logic          o_dmem_read,
    output logic          o_dmem_write
);

    lc3b_if_id_s   if_id;
    lc3b_id_ex_s   id_ex;
    lc3b_ex_mem_s  ex_mem;
    lc3b_mem_wb_s  mem_wb;
    logic          advance;
    logic          bubble;
    logic          hold_pc;
    logic          flush;
    logic          redirect;
    lc3b_word      target;
    logic          rf_we;
    lc3b_reg       rf_dest;
    lc3b_word      rf_data;
    lc3b_reg       id_src_a;
    lc3b_reg       id_src_b;
    lc3b_word      mem_fwd;
    lc3b_word      wb_fwd;
    lc3b_fwd_sel_e fwd_a;
    lc3b_fwd_sel_e fwd_b;

    fetch_stage #(.P_RESET_PC(P_RESET_PC)) u_fetch (
        .clk, .i_rst, .i_advance(advance), .i_hold_pc(hold_pc), .i_flush(flush),
        .i_redirect(redirect), .i_target(target), .i_imem_resp, .i_imem_rdata,
        .o_imem_address, .o_imem_read, .o_if_id(if_id)
    );

    decode_stage u_decode (
        .clk, .i_rst, .i_advance(advance), .i_bubble(bubble), .i_flush(flush),
        .i_if_id(if_id), .i_rf_we(rf_we), .i_rf_dest(rf_dest), .i_rf_data(rf_data),
        .o_src_a(id_src_a), .o_src_b(id_src_b), .o_id_ex(id_ex)
    );

    execute_stage u_execute (
        .clk, .i_rst, .i_advance(advance), .i_flush(flush), .i_id_ex(id_ex),
        .i_fwd_a(fwd_a), .i_fwd_b(fwd_b), .i_mem_fwd(mem_fwd), .i_wb_fwd(wb_fwd),
        .o_ex_mem(ex_mem)
    );

    memory_stage u_memory (
        .clk, .i_rst, .i_advance(advance), .i_flush(flush), .i_ex_mem(ex_mem),
        .i_dmem_resp, .i_dmem_rdata, .o_dmem_address, .o_dmem_wdata,
        .o_dmem_read, .o_dmem_write, .o_mem_fwd(mem_fwd), .o_mem_wb(mem_wb)
    );

    writeback_stage u_writeback (
        .clk, .i_rst, .i_advance(advance), .i_mem_wb(mem_wb),
        .o_rf_we(rf_we), .o_rf_dest(rf_dest), .o_rf_data(rf_data), .o_wb_fwd(wb_fwd),
        .o_redirect(redirect), .o_target(target)
    );

    hazard_unit u_hazard (
        .i_imem_read(o_imem_read), .i_imem_resp,
        .i_dmem_req(o_dmem_read | o_dmem_write), .i_dmem_resp,
        .i_redirect(redirect), .i_id_ex(id_ex), .i_ex_mem(ex_mem), .i_mem_wb(mem_wb),
        .i_id_src_a(id_src_a), .i_id_src_b(id_src_b),
        .o_advance(advance), .o_bubble(bubble), .o_hold_pc(hold_pc), .o_flush(flush),
        .o_fwd_a(fwd_a), .o_fwd_b(fwd_b)
    );

endmodule : cpu_top

`default_nettype wire

// ==== tests/cpu_top_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_top_asserts
    import lc3b_isa_pkg::*;
#(
    parameter lc3b_word P_RESET_PC = 16'h0000
) (
    input wire           clk,
    input wire           i_rst,
    input wire           i_imem_resp,
    input wire lc3b_word o_imem_address,
    input wire           o_imem_read,
    input wire           i_dmem_resp,
    input wire lc3b_word o_dmem_address,
    input wire lc3b_word o_dmem_wdata,
    input wire           o_dmem_read,
    input wire           o_dmem_write
);

    // number of failed checks, watched by the testbench
    int err_count = 0;

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (i_rst)
        !(o_dmem_read && o_dmem_write))
    else begin
        err_count++;
        $error("dmem read and write requested in the same cycle");
    end

    // a pending read keeps its request and address
    a_dmem_read_held: assert property (@(posedge clk) disable iff (i_rst)
        o_dmem_read && !i_dmem_resp |=> o_dmem_read && $stable(o_dmem_address))
    else begin
        err_count++;
        $error("dmem read dropped or moved before its response, address now %h",
               o_dmem_address);
    end

    a_dmem_write_held: assert property (@(posedge clk) disable iff (i_rst)
        o_dmem_write && !i_dmem_resp |=>
            o_dmem_write && $stable(o_dmem_address) && $stable(o_dmem_wdata))
    else begin
        err_count++;
        $error("dmem write dropped or changed before its response, %h at %h",
               o_dmem_wdata, o_dmem_address);
    end

    a_imem_read_held: assert property (@(posedge clk) disable iff (i_rst)
        o_imem_read && !i_imem_resp |=> o_imem_read && $stable(o_imem_address))
    else begin
        err_count++;
        $error("imem read dropped or moved before its response, address now %h",
               o_imem_address);
    end

    // word accesses only
    a_dmem_aligned: assert property (@(posedge clk) disable iff (i_rst)
        (o_dmem_read || o_dmem_write) |-> !o_dmem_address[0])
    else begin
        err_count++;
        $error("odd dmem address %h", o_dmem_address);
    end

    a_reset_quiet: assert property (@(posedge clk)
        i_rst |=> !o_dmem_read && !o_dmem_write)
    else begin
        err_count++;
        $error("dmem request during or right after reset");
    end

    // fetch starts one cycle after reset is released
    a_first_fetch: assert property (@(posedge clk)
        i_rst ##1 !i_rst |=> o_imem_read && o_imem_address == P_RESET_PC)
    else begin
        err_count++;
        $error("first fetch missing or at %h instead of %h", o_imem_address, P_RESET_PC);
    end

endmodule : cpu_top_asserts

`default_nettype wire

// ==== tests/tb_cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu
    import lc3b_isa_pkg::*;
();

    localparam int       CLK_PERIOD = 20;
    localparam int       N_INSTR    = 52;
    localparam int       N_STORES   = 14;
    localparam lc3b_word P_RESET_PC = 16'h0000;

    typedef struct packed {
        lc3b_word addr;
        lc3b_word data;
    } store_s;

    // r7 is the result pointer, r0 stays zero
    localparam lc3b_word PROGRAM [N_INSTR] = '{
        16'h5020, 16'h5FE0,  // and r0,r0,#0 / and r7,r7,#0
        16'h1FE8, 16'h1FC7,  // add r7,r7,#8 / add r7,r7,r7
        16'h1FC7, 16'h1FC7,  // r7 = 0x40
        16'h1225,            // add r1,r0,#5
        16'h147D,            // add r2,r1,#-3
        16'h5642,            // and r3,r1,r2
        16'h987F,            // not r4,r1
        16'h1B02,            // add r5,r4,r2
        16'h5D6F,            // and r6,r5,#15
        16'h73C0, 16'h75C1,  // str r1..r6 to r7+0..5
        16'h77C2, 16'h79C3,
        16'h7BC4, 16'h7DC5,
        16'h1385,            // add r1,r6,r5
        16'h73C6,            // str r1,r7,#6 right behind its producer
        16'h6401,            // ldr r2,r0,#1
        16'h16A1,            // add r3,r2,#1 load-use
        16'h77C7,            // str r3,r7,#7
        16'h6803,            // ldr r4,r0,#3
        16'h79C8,            // str r4,r7,#8 load-use on store data
        16'h0801,            // brn, not taken
        16'h0201,            // brp, taken
        16'h71DF,            // skipped
        16'h5B60,            // and r5,r5,#0
        16'h0402,            // brz +2, taken
        16'h71DF, 16'h71DF,  // skipped
        16'h7BC9,            // str r5,r7,#9
        16'h0A01,            // brnp, not taken
        16'h7DCA,            // str r6,r7,#10
        16'h6201,            // ldr r1,r0,#1 negative
        16'h0601,            // brzp, not taken
        16'h0801,            // brn, taken
        16'h71DF,            // skipped
        16'h73CB,            // str r1,r7,#11
        16'h6402,            // ldr r2,r0,#2 zero
        16'h0401,            // brz, taken
        16'h71DF,            // skipped
        16'h96BF,            // not r3,r2
        16'h0201,            // brp, not taken
        16'h0801,            // brn, taken
        16'h71DF,            // skipped
        16'h18E2,            // add r4,r3,#2
        16'h0C01,            // brnz, not taken
        16'h79CC,            // str r4,r7,#12
        16'h77CD,            // str r3,r7,#13
        16'h0FFF             // spin here
    };

    localparam store_s EXP_STORES [N_STORES] = '{
        {16'h0040, 16'h0005},
        {16'h0042, 16'h0002},
        {16'h0044, 16'h0000},
        {16'h0046, 16'hFFFA},
        {16'h0048, 16'hFFFC},
        {16'h004A, 16'h000C},
        {16'h004C, 16'h0008},
        {16'h004E, 16'h9012},
        {16'h0050, 16'h1234},
        {16'h0052, 16'h0000},
        {16'h0054, 16'h000C},
        {16'h0056, 16'h9011},
        {16'h0058, 16'h0001},
        {16'h005A, 16'hFFFF}
    };

    logic     clk;
    logic     i_rst;
    logic     i_imem_resp;
    lc3b_word i_imem_rdata;
    lc3b_word o_imem_address;
    logic     o_imem_read;
    logic     i_dmem_resp;
    lc3b_word i_dmem_rdata;
    lc3b_word o_dmem_address;
    lc3b_word o_dmem_wdata;
    logic     o_dmem_read;
    logic     o_dmem_write;
    lc3b_word imem [256];
    lc3b_word dmem [256];
    integer   seed;
    int       store_count = 0;

    cpu_top #(.P_RESET_PC(P_RESET_PC)) UUT (
        .clk, .i_rst, .i_imem_resp, .i_imem_rdata, .o_imem_address, .o_imem_read,
        .i_dmem_resp, .i_dmem_rdata, .o_dmem_address, .o_dmem_wdata,
        .o_dmem_read, .o_dmem_write
    );

    bind cpu_top cpu_top_asserts #(.P_RESET_PC(P_RESET_PC)) u_asserts (
        .clk, .i_rst, .i_imem_resp, .o_imem_address, .o_imem_read,
        .i_dmem_resp, .o_dmem_address, .o_dmem_wdata, .o_dmem_read, .o_dmem_write
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_store(input lc3b_word addr, input lc3b_word data);
        store_s exp;
        exp = EXP_STORES[store_count];
        assert (addr == exp.addr) else begin
            abort_run($sformatf("FAIL o_dmem_address store %0d: got %h, expected %h",
                                store_count, addr, exp.addr));
        end
        assert (data == exp.data) else begin
            abort_run($sformatf("FAIL o_dmem_wdata store %0d: got %h, expected %h",
                                store_count, data, exp.data));
        end
        store_count++;
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin : reset_seq
        i_rst = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        i_rst = 1'b0;
    end

    // both memories answer after 0 to 3 wait cycles
    initial begin : memories
        logic i_busy;
        logic d_busy;
        int   i_wait;
        int   d_wait;
        seed         = 32'ha64c;
        i_busy       = 1'b0;
        d_busy       = 1'b0;
        i_wait       = 0;
        d_wait       = 0;
        i_imem_resp  = 1'b0;
        i_imem_rdata = '0;
        i_dmem_resp  = 1'b0;
        i_dmem_rdata = '0;
        for (int i = 0; i < 256; i++) begin
            // br with a clear nzp mask never branches
            imem[i] = 16'(i);
            dmem[i] = 16'h9000 + 16'(i) * 16'h0011;
        end
        for (int i = 0; i < N_INSTR; i++) begin
            imem[i] = PROGRAM[i];
        end
        dmem[2] = 16'h0000;
        dmem[3] = 16'h1234;

        while (store_count < N_STORES) begin
            @(posedge clk);
            #2;
            // a response lasts one cycle
            if (i_imem_resp) begin
                i_imem_resp = 1'b0;
                i_busy      = 1'b0;
            end
            if (i_dmem_resp) begin
                i_dmem_resp = 1'b0;
                d_busy      = 1'b0;
            end

            if (!o_imem_read) begin
                i_busy = 1'b0;
            end else if (!i_busy) begin
                i_busy = 1'b1;
                i_wait = $random(seed) & 3;
            end
            if (i_busy) begin
                if (i_wait == 0) begin
                    i_imem_resp  = 1'b1;
                    i_imem_rdata = imem[o_imem_address[8:1]];
                end else begin
                    i_wait--;
                end
            end

            if (!(o_dmem_read || o_dmem_write)) begin
                d_busy = 1'b0;
            end else if (!d_busy) begin
                d_busy = 1'b1;
                d_wait = $random(seed) & 3;
            end
            if (d_busy) begin
                if (d_wait == 0) begin
                    i_dmem_resp = 1'b1;
                    if (o_dmem_write) begin
                        check_store(o_dmem_address, o_dmem_wdata);
                        dmem[o_dmem_address[8:1]] = o_dmem_wdata;
                    end else begin
                        i_dmem_rdata = dmem[o_dmem_address[8:1]];
                    end
                end else begin
                    d_wait--;
                end
            end
        end

        if (UUT.u_asserts.err_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            abort_run("a bound assertion failed before the last store");
        end
    end

    always @(posedge clk) begin
        #1;
        if (UUT.u_asserts.err_count != 0) begin
            abort_run("a bound assertion on the memory ports failed, see the error above");
        end
    end

    // 200 cycles for each instruction of the program
    initial begin : watchdog
        #(N_INSTR * 200 * CLK_PERIOD);
        abort_run($sformatf("watchdog expired after %0d cycles, %0d of %0d stores seen",
                            N_INSTR * 200, store_count, N_STORES));
    end

endmodule : tb_cpu

`default_nettype wire

// ==== project.f ====
common/lc3b_isa_pkg.sv
common/lc3b_pipe_pkg.sv
pipeline/fetch_stage.sv
pipeline/decode_stage.sv
pipeline/execute_stage.sv
pipeline/memory_stage.sv
pipeline/writeback_stage.sv
source/hazard_unit.sv
source/cpu_top.sv
tests/cpu_top_asserts.sv
tests/tb_cpu.sv

// ==== Makefile ====
TOP = tb_cpu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

# the error limit lets the testbench see a failed bound assertion and end the run itself
sim:
	verilator --binary --assert -j 0 -f project.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100

clean:
	rm -rf obj_dir
